// File: src/fetch_pkg.sv
// Fetch front end definitions
`default_nettype none

package fetch_pkg;

	//////////////////////////////////////////////////
	// Widths and fixed addresses
	//////////////////////////////////////////////////

	// Instruction and address width
	localparam int XLEN = 32;

	// First fetch address out of reset
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0100;

	//////////////////////////////////////////////////
	// Primary opcodes
	//////////////////////////////////////////////////

	// Unconditional jump with 26-bit word offset
	localparam logic [5:0] OPC_J   = 6'h00;
	// No-operation
	localparam logic [5:0] OPC_NOP = 6'h05;

	// Filler word for errored or dropped fetches
	localparam logic [XLEN-1:0] NOP_INSN = {OPC_NOP, 26'h041_0000};

	//////////////////////////////////////////////////
	// Bus error tags
	//////////////////////////////////////////////////

	// TLB miss
	localparam logic [3:0] TAG_ITLB  = 4'hd;
	// Page fault
	localparam logic [3:0] TAG_IPAGE = 4'hc;
	// Plain bus error
	localparam logic [3:0] TAG_IBUS  = 4'hb;

	// Opcode class seen by decode
	typedef enum logic [1:0] {
		OP_JUMP,
		OP_NOP,
		OP_OTHER
	} opcode_e;

	// Fetch exception carried with each word
	typedef enum logic [1:0] {
		EXC_NONE,
		EXC_ITLB,
		EXC_IPAGE,
		EXC_IBUS
	} exc_e;

endpackage

`default_nettype wire

// File: src/pc_gen.sv
// Fetch address generator
`default_nettype none

module pc_gen import fetch_pkg::*; (
	input  wire logic            clk,
	input  wire logic            reset_i,
	input  wire logic            freeze_i,
	input  wire logic            flush_i,
	input  wire logic [XLEN-1:0] flush_pc_i,
	input  wire logic            ibus_ack_i,
	input  wire logic            ibus_err_i,
	input  wire logic            f_hold_full_i,
	input  wire logic            jump_taken_i,
	input  wire logic [XLEN-1:0] jump_pc_i,
	output logic                 ibus_req_o,
	output logic [XLEN-1:0]      ibus_adr_o,
	output logic                 fetch_stale_o
);

	// Fetch PC of the current or next transfer
	logic [XLEN-1:0] pc_q;
	// Request enable, low only in reset
	logic            req_q;
	// Outstanding transfer belongs to a flushed PC
	logic            stale_q;
	// Redirect target waiting for the stale response
	logic [XLEN-1:0] flush_pc_q;

	logic            done;
	logic            advance;

	// Transfer ends on ack or err
	assign done = ibus_req_o & (ibus_ack_i | ibus_err_i);

	// Word leaves fetch for decode this cycle
	// either straight off the bus or out of the hold stage
	assign advance = !freeze_i & (done | f_hold_full_i);

	// Hold stage full means a frozen word is parked
	assign ibus_req_o    = req_q & !f_hold_full_i;
	assign ibus_adr_o    = {pc_q[XLEN-1:2], 2'b00};
	assign fetch_stale_o = stale_q;

	//////////////////////////////////////////////////
	// PC and redirect control
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_i) begin
			pc_q    <= RESET_PC;
			req_q   <= 1'b0;
			stale_q <= 1'b0;
		end else begin
			req_q <= 1'b1;
			if (flush_i) begin
				// Address is frozen until the old transfer ends
				if (ibus_req_o && !done) begin
					stale_q <= 1'b1;
				end else begin
					stale_q <= 1'b0;
					pc_q    <= flush_pc_i;
				end
			end else if (stale_q) begin
				// Dropped response done, now go to the flush target
				if (done) begin
					stale_q <= 1'b0;
					pc_q    <= flush_pc_q;
				end
			end else if (advance) begin
				// Jump beats the sequential step
				if (jump_taken_i)
					pc_q <= jump_pc_i;
				else
					pc_q <= pc_q + XLEN'(4);
			end
		end
	end

	// Latest flush target, read once the stale transfer ends
	always_ff @(posedge clk) begin
		if (flush_i)
			flush_pc_q <= flush_pc_i;
	end

endmodule

`default_nettype wire

// File: src/fetch_hold.sv
// Fetch result and freeze hold
`default_nettype none

module fetch_hold import fetch_pkg::*; (
	input  wire logic            clk,
	input  wire logic            reset_i,
	input  wire logic            freeze_i,
	input  wire logic            flush_i,
	input  wire logic            fetch_stale_i,
	input  wire logic [XLEN-1:0] ibus_adr_i,
	input  wire logic [XLEN-1:0] ibus_dat_i,
	input  wire logic            ibus_ack_i,
	input  wire logic            ibus_err_i,
	input  wire logic [3:0]      ibus_tag_i,
	output logic                 f_valid_o,
	output logic [XLEN-1:0]      f_insn_o,
	output logic [XLEN-1:0]      f_pc_o,
	output exc_e                 f_exc_o,
	output logic                 f_hold_full_o
);

	// Response qualifiers
	logic            done;
	logic            live;
	logic            save;

	// Response after error substitution
	logic [XLEN-1:0] resp_insn;
	logic [XLEN-1:0] resp_pc;
	exc_e            resp_exc;

	// Parked word
	logic            saved_q;
	logic [XLEN-1:0] insn_saved_q;
	logic [XLEN-1:0] addr_saved_q;
	exc_e            exc_saved_q;

	// Memory answers only an active request
	assign done = ibus_ack_i | ibus_err_i;

	// Responses to a flushed PC are thrown away
	assign live = done & !fetch_stale_i;

	// Decode cannot take it now, so park it
	assign save = live & freeze_i & !flush_i & !saved_q;

	//////////////////////////////////////////////////
	// Response shaping
	//////////////////////////////////////////////////

	// Errored words never reach decode as data
	assign resp_insn = ibus_err_i ? NOP_INSN : ibus_dat_i;
	assign resp_pc   = {ibus_adr_i[XLEN-1:2], 2'b00};

	// Error tag to exception class
	always_comb begin
		resp_exc = EXC_NONE;
		if (ibus_err_i) begin
			case (ibus_tag_i)
				TAG_ITLB:  resp_exc = EXC_ITLB;
				TAG_IPAGE: resp_exc = EXC_IPAGE;
				TAG_IBUS:  resp_exc = EXC_IBUS;
				// Unknown tags still count as bus errors
				default:   resp_exc = EXC_IBUS;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Hold register
	//////////////////////////////////////////////////

	// Full flag drains on the first unfrozen cycle
	always_ff @(posedge clk) begin
		if (reset_i)
			saved_q <= 1'b0;
		else if (flush_i)
			saved_q <= 1'b0;
		else if (save)
			saved_q <= 1'b1;
		else if (!freeze_i)
			saved_q <= 1'b0;
	end

	// Word, address and exception captured together
	always_ff @(posedge clk) begin
		if (save) begin
			insn_saved_q <= resp_insn;
			addr_saved_q <= resp_pc;
			exc_saved_q  <= resp_exc;
		end
	end

	//////////////////////////////////////////////////
	// Output select
	//////////////////////////////////////////////////

	// Parked word wins, the bus is idle while it sits here
	assign f_valid_o     = saved_q | live;
	assign f_insn_o      = saved_q ? insn_saved_q : resp_insn;
	assign f_pc_o        = saved_q ? addr_saved_q : resp_pc;
	assign f_exc_o       = saved_q ? exc_saved_q : resp_exc;
	assign f_hold_full_o = saved_q;

endmodule

`default_nettype wire

// File: src/insn_decode.sv
// Instruction decode register
`default_nettype none

module insn_decode import fetch_pkg::*; (
	input  wire logic            clk,
	input  wire logic            reset_i,
	input  wire logic            freeze_i,
	input  wire logic            flush_i,
	input  wire logic            f_valid_i,
	input  wire logic [XLEN-1:0] f_insn_i,
	input  wire logic [XLEN-1:0] f_pc_i,
	input  wire exc_e            f_exc_i,
	output logic                 jump_taken_o,
	output logic [XLEN-1:0]      jump_pc_o,
	output logic                 dec_valid_o,
	output logic [XLEN-1:0]      dec_pc_o,
	output logic [XLEN-1:0]      dec_insn_o,
	output opcode_e              dec_op_o,
	output exc_e                 dec_exc_o
);

	// Incoming word is taken this cycle
	logic            accept;
	// Class of the incoming word
	opcode_e         f_op;
	// Byte offset from the 26-bit jump field
	logic [XLEN-1:0] jump_ofs;

	// Registered stage
	logic            valid_q;
	logic [XLEN-1:0] pc_q;
	logic [XLEN-1:0] insn_q;
	opcode_e         op_q;
	exc_e            exc_q;

	assign accept = f_valid_i & !freeze_i & !flush_i;

	//////////////////////////////////////////////////
	// Classify and resolve jumps
	//////////////////////////////////////////////////

	// Primary opcode sits in the top six bits
	always_comb begin
		case (f_insn_i[XLEN-1:XLEN-6])
			OPC_J:   f_op = OP_JUMP;
			OPC_NOP: f_op = OP_NOP;
			default: f_op = OP_OTHER;
		endcase
	end

	// Sign extend and scale to bytes
	assign jump_ofs = {{(XLEN-28){f_insn_i[25]}}, f_insn_i[25:0], 2'b00};

	// Target relative to the jump's own PC
	assign jump_pc_o = f_pc_i + jump_ofs;

	// Only a clean jump redirects fetch
	// and pc_gen samples this on the same edge decode loads
	assign jump_taken_o = accept & (f_op == OP_JUMP) & (f_exc_i == EXC_NONE);

	//////////////////////////////////////////////////
	// Decode register
	//////////////////////////////////////////////////

	// Valid holds under freeze, flush kills it
	always_ff @(posedge clk) begin
		if (reset_i)
			valid_q <= 1'b0;
		else if (flush_i)
			valid_q <= 1'b0;
		else if (!freeze_i)
			valid_q <= f_valid_i;
	end

	// Contents only change when a word is accepted
	always_ff @(posedge clk) begin
		if (accept) begin
			pc_q   <= f_pc_i;
			insn_q <= f_insn_i;
			op_q   <= f_op;
			exc_q  <= f_exc_i;
		end
	end

	assign dec_valid_o = valid_q;
	assign dec_pc_o    = pc_q;
	assign dec_insn_o  = insn_q;
	assign dec_op_o    = op_q;
	assign dec_exc_o   = exc_q;

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
// Instruction fetch unit top
`default_nettype none

module fetch_unit import fetch_pkg::*; (
	input  wire logic            clk,
	input  wire logic            reset_i,
	// Pipeline control
	input  wire logic            freeze_i,
	input  wire logic            flush_i,
	input  wire logic [XLEN-1:0] flush_pc_i,
	// Instruction bus
	input  wire logic [XLEN-1:0] ibus_dat_i,
	input  wire logic            ibus_ack_i,
	input  wire logic            ibus_err_i,
	input  wire logic [3:0]      ibus_tag_i,
	output logic                 ibus_req_o,
	output logic [XLEN-1:0]      ibus_adr_o,
	// Decode stage out
	output logic                 dec_valid_o,
	output logic [XLEN-1:0]      dec_pc_o,
	output logic [XLEN-1:0]      dec_insn_o,
	output opcode_e              dec_op_o,
	output exc_e                 dec_exc_o
);

	// Address generator to hold stage
	logic            fetch_stale;

	// Hold stage to decode
	logic            f_valid;
	logic [XLEN-1:0] f_insn;
	logic [XLEN-1:0] f_pc;
	exc_e            f_exc;
	logic            f_hold_full;

	// Decode back to address generator
	logic            jump_taken;
	logic [XLEN-1:0] jump_pc;

	//////////////////////////////////////////////////
	// Next address and bus request
	//////////////////////////////////////////////////

	pc_gen u_pc_gen (
		.clk           (clk),
		.reset_i       (reset_i),
		.freeze_i      (freeze_i),
		.flush_i       (flush_i),
		.flush_pc_i    (flush_pc_i),
		.ibus_ack_i    (ibus_ack_i),
		.ibus_err_i    (ibus_err_i),
		.f_hold_full_i (f_hold_full),
		.jump_taken_i  (jump_taken),
		.jump_pc_i     (jump_pc),
		.ibus_req_o    (ibus_req_o),
		.ibus_adr_o    (ibus_adr_o),
		.fetch_stale_o (fetch_stale)
	);

	// Response capture and error mapping
	fetch_hold u_fetch_hold (
		.clk           (clk),
		.reset_i       (reset_i),
		.freeze_i      (freeze_i),
		.flush_i       (flush_i),
		.fetch_stale_i (fetch_stale),
		.ibus_adr_i    (ibus_adr_o),
		.ibus_dat_i    (ibus_dat_i),
		.ibus_ack_i    (ibus_ack_i),
		.ibus_err_i    (ibus_err_i),
		.ibus_tag_i    (ibus_tag_i),
		.f_valid_o     (f_valid),
		.f_insn_o      (f_insn),
		.f_pc_o        (f_pc),
		.f_exc_o       (f_exc),
		.f_hold_full_o (f_hold_full)
	);

	// Decode register
	insn_decode u_insn_decode (
		.clk          (clk),
		.reset_i      (reset_i),
		.freeze_i     (freeze_i),
		.flush_i      (flush_i),
		.f_valid_i    (f_valid),
		.f_insn_i     (f_insn),
		.f_pc_i       (f_pc),
		.f_exc_i      (f_exc),
		.jump_taken_o (jump_taken),
		.jump_pc_o    (jump_pc),
		.dec_valid_o  (dec_valid_o),
		.dec_pc_o     (dec_pc_o),
		.dec_insn_o   (dec_insn_o),
		.dec_op_o     (dec_op_o),
		.dec_exc_o    (dec_exc_o)
	);

endmodule

`default_nettype wire

// File: test/tb_fetch_unit.sv
// Fetch unit testbench
`default_nettype none

module tb_fetch_unit import fetch_pkg::*; ();

	// About four times the longest run at three wait states
	localparam int MAX_CYCLES = 2000;

	logic            clk;
	logic            reset_i;
	logic            freeze_i;
	logic            flush_i;
	logic [XLEN-1:0] flush_pc_i;
	logic [XLEN-1:0] ibus_dat_i;
	logic            ibus_ack_i;
	logic            ibus_err_i;
	logic [3:0]      ibus_tag_i;
	logic            ibus_req_o;
	logic [XLEN-1:0] ibus_adr_o;
	logic            dec_valid_o;
	logic [XLEN-1:0] dec_pc_o;
	logic [XLEN-1:0] dec_insn_o;
	opcode_e         dec_op_o;
	exc_e            dec_exc_o;

	// Memory model with one entry per word
	logic [XLEN-1:0] mem_data [256];
	logic            err_en [256];
	logic [3:0]      err_tag [256];
	logic            mem_busy;
	int              mem_wait;
	// Forced wait for the next transfer
	// Zero means a random wait
	int              long_wait;

	// Words taken by the pipeline
	logic [XLEN-1:0] got_pc[$];
	logic [XLEN-1:0] got_insn[$];
	opcode_e         got_op[$];
	exc_e            got_exc[$];

	int cycles;
	int errors;
	int tests;
	int failed_tests;

	fetch_unit uut (.*);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	//////////////////////////////////////////////////
	// Bus slave with random wait states
	//////////////////////////////////////////////////

	always @(negedge clk) begin : slave
		logic       ended;
		logic [7:0] idx;
		ended = ibus_ack_i | ibus_err_i;
		ibus_ack_i = 1'b0;
		ibus_err_i = 1'b0;
		ibus_tag_i = 4'h0;
		if (reset_i || ended)
			mem_busy = 1'b0;
		if (!reset_i && ibus_req_o) begin
			// New transfer picks its wait count once
			if (!mem_busy) begin
				mem_busy = 1'b1;
				if (long_wait > 0) begin
					mem_wait = long_wait;
					long_wait = 0;
				end else
					mem_wait = $urandom % 4;
			end
			if (mem_wait == 0) begin
				idx = ibus_adr_o[9:2];
				if (err_en[idx]) begin
					ibus_err_i = 1'b1;
					ibus_tag_i = err_tag[idx];
					ibus_dat_i = 32'hdead_beef;
				end else begin
					ibus_ack_i = 1'b1;
					ibus_dat_i = mem_data[idx];
				end
			end else
				mem_wait--;
		end
	end

	// Pipeline consumes a word when not frozen or flushed
	always @(posedge clk) begin
		if (!reset_i && dec_valid_o && !freeze_i && !flush_i) begin
			got_pc.push_back(dec_pc_o);
			got_insn.push_back(dec_insn_o);
			got_op.push_back(dec_op_o);
			got_exc.push_back(dec_exc_o);
		end
	end

	// Watchdog
	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run stopped after %0d cycles", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Compare and helper tasks
	//////////////////////////////////////////////////

	task automatic check_word(input string name, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_op(input string name, input opcode_e got, input opcode_e exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_exc(input string name, input exc_e got, input exc_e exp);
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		tests++;
		if (errors == start_errors)
			$display("Test %s: ok", name);
		else begin
			failed_tests++;
			$display("Test %s: %0d checks failed", name, errors - start_errors);
		end
	endtask

	// Unknown tags count as bus errors
	function automatic exc_e exc_for_tag(input logic [3:0] tag);
		if (tag == TAG_ITLB)
			return EXC_ITLB;
		if (tag == TAG_IPAGE)
			return EXC_IPAGE;
		return EXC_IBUS;
	endfunction

	task automatic load_memory();
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] fill;
		for (int i = 0; i < 256; i++) begin
			addr = i * 4;
			fill = addr ^ (addr << 11) ^ 32'h0055_aa00;
			mem_data[i] = {6'h38, fill[25:0]};
			err_en[i] = 1'b0;
			err_tag[i] = 4'h0;
		end
		mem_data[8'h43] = {OPC_NOP, 26'h0};
		// Jump at 0x200 to 16 words ahead
		mem_data[8'h80] = {OPC_J, 26'd16};
		// Error words from 0x2c0
		// Last one has an unknown tag
		err_en[8'hb0] = 1'b1;
		err_tag[8'hb0] = TAG_ITLB;
		err_en[8'hb2] = 1'b1;
		err_tag[8'hb2] = TAG_IPAGE;
		err_en[8'hb3] = 1'b1;
		err_tag[8'hb3] = TAG_IBUS;
		err_en[8'hb5] = 1'b1;
		err_tag[8'hb5] = 4'h7;
	endtask

	task automatic wait_consumed(input int n);
		while (got_pc.size() < n)
			@(negedge clk);
	endtask

	// One flush cycle before fetch restarts at the target
	task automatic redirect(input logic [XLEN-1:0] target);
		@(negedge clk);
		flush_i = 1'b1;
		flush_pc_i = target;
		@(negedge clk);
		flush_i = 1'b0;
		freeze_i = 1'b0;
		got_pc.delete();
		got_insn.delete();
		got_op.delete();
		got_exc.delete();
	endtask

	// Walk the expected program from start_pc against n consumed words
	task automatic check_stream(input logic [XLEN-1:0] start_pc, input int n);
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] insn;
		opcode_e         op;
		exc_e            exc;
		int              ofs;
		pc = start_pc;
		for (int i = 0; i < n; i++) begin
			insn = mem_data[pc[9:2]];
			exc = EXC_NONE;
			if (err_en[pc[9:2]]) begin
				insn = NOP_INSN;
				exc = exc_for_tag(err_tag[pc[9:2]]);
			end
			if (insn[31:26] == OPC_J)
				op = OP_JUMP;
			else if (insn[31:26] == OPC_NOP)
				op = OP_NOP;
			else
				op = OP_OTHER;
			check_word("dec_pc_o", got_pc.pop_front(), pc);
			check_word("dec_insn_o", got_insn.pop_front(), insn);
			check_op("dec_op_o", got_op.pop_front(), op);
			check_exc("dec_exc_o", got_exc.pop_front(), exc);
			// Signed word offset turned into bytes
			ofs = int'($signed(insn[25:0]));
			if (op == OP_JUMP && exc == EXC_NONE)
				pc = pc + ofs * 4;
			else
				pc = pc + 4;
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic reset_and_sequential();
		int e0;
		e0 = errors;
		@(posedge clk);
		@(negedge clk);
		check_word("ibus_req_o", XLEN'(ibus_req_o), XLEN'(1'b1));
		check_word("ibus_adr_o", ibus_adr_o, RESET_PC);
		wait_consumed(6);
		check_stream(RESET_PC, 6);
		report_test("reset and sequential fetch", e0);
	endtask

	task automatic freeze_mid_stream();
		int              e0;
		logic            hold_valid;
		logic [XLEN-1:0] hold_pc;
		logic [XLEN-1:0] hold_insn;
		opcode_e         hold_op;
		exc_e            hold_exc;
		e0 = errors;
		redirect(32'h140);
		wait_consumed(3);
		freeze_i = 1'b1;
		hold_valid = dec_valid_o;
		hold_pc = dec_pc_o;
		hold_insn = dec_insn_o;
		hold_op = dec_op_o;
		hold_exc = dec_exc_o;
		repeat (6) begin
			@(negedge clk);
			check_word("dec_valid_o", XLEN'(dec_valid_o), XLEN'(hold_valid));
			check_word("dec_pc_o", dec_pc_o, hold_pc);
			check_word("dec_insn_o", dec_insn_o, hold_insn);
			check_op("dec_op_o", dec_op_o, hold_op);
			check_exc("dec_exc_o", dec_exc_o, hold_exc);
		end
		freeze_i = 1'b0;
		wait_consumed(10);
		check_stream(32'h140, 10);
		report_test("freeze", e0);
	endtask

	task automatic forward_jump();
		int e0;
		e0 = errors;
		redirect(32'h1f8);
		wait_consumed(5);
		check_op("dec_op_o", got_op[2], OP_JUMP);
		check_word("dec_pc_o", got_pc[3], 32'h240);
		check_stream(32'h1f8, 5);
		report_test("jump", e0);
	endtask

	task automatic error_tags();
		int e0;
		e0 = errors;
		redirect(32'h2bc);
		wait_consumed(8);
		check_stream(32'h2bc, 8);
		report_test("error tags", e0);
	endtask

	task automatic flush_in_flight();
		int              e0;
		logic [XLEN-1:0] stale_pc;
		e0 = errors;
		@(posedge clk);
		long_wait = 8;
		// Flush only once the long transfer is well under way
		do
			@(posedge clk);
		while (!(mem_busy && mem_wait > 3));
		stale_pc = ibus_adr_o;
		redirect(32'h300);
		wait_consumed(4);
		for (int i = 0; i < got_pc.size(); i++) begin
			if (got_pc[i] == stale_pc) begin
				errors++;
				$display("Flushed response from %h reached decode", stale_pc);
			end
		end
		check_stream(32'h300, 4);
		report_test("flush mid-transfer", e0);
	endtask

	task automatic flush_saved_word();
		int e0;
		e0 = errors;
		redirect(32'h180);
		wait_consumed(2);
		freeze_i = 1'b1;
		// Request drops once a word is parked
		do
			@(negedge clk);
		while (ibus_req_o);
		redirect(32'h1c0);
		wait_consumed(4);
		check_stream(32'h1c0, 4);
		report_test("flush with saved word", e0);
	endtask

	initial begin
		void'($urandom(32'haafd));
		reset_i = 1'b1;
		freeze_i = 1'b0;
		flush_i = 1'b0;
		flush_pc_i = '0;
		ibus_dat_i = '0;
		ibus_ack_i = 1'b0;
		ibus_err_i = 1'b0;
		ibus_tag_i = 4'h0;
		mem_busy = 1'b0;
		mem_wait = 0;
		long_wait = 0;
		cycles = 0;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		load_memory();
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;

		reset_and_sequential();
		freeze_mid_stream();
		forward_jump();
		error_tags();
		flush_in_flight();
		flush_saved_word();

		$display("%0d tests run, %0d failed, %0d checks failed", tests, failed_tests, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
src/fetch_pkg.sv
src/pc_gen.sv
src/fetch_hold.sv
src/insn_decode.sv
src/fetch_unit.sv
test/tb_fetch_unit.sv
